//--- sim/bridge_stim.txt
// wr size vaddr wdata exp_paddr exp_strb exp_cache exp_rdata
// size 0 byte, 1 half, 2 word; exp_rdata is unused on writes
1 2 80001000 11223344 00001000 f f 00000000
0 2 a0001000 00000000 00001000 f 0 11223344
1 0 80001001 0000aa00 00001001 2 f 00000000
1 1 80001002 beef0000 00001002 c f 00000000
0 2 80001000 00000000 00001000 f f beefaa44
1 2 00002000 cafef00d 00002000 f f 00000000
1 0 00002003 5a000000 00002003 8 f 00000000
0 1 00002002 00000000 00002002 c f 5afef00d
1 2 c0003000 01234567 c0003000 f f 00000000
0 0 c0003001 00000000 c0003001 2 f 01234567
1 1 a0004000 0000abcd 00004000 3 0 00000000
1 1 a0004002 12340000 00004002 c 0 00000000
0 2 80004000 00000000 00004000 f f 1234abcd
1 0 a0004000 000000ee 00004000 1 0 00000000
0 0 a0004000 00000000 00004000 1 0 1234abee
1 2 bffffffc 87654321 1ffffffc f 0 00000000
0 2 9ffffffc 00000000 1ffffffc f f 87654321
1 2 7ffffff0 0f0f0f0f 7ffffff0 f f 00000000
0 2 7ffffff0 00000000 7ffffff0 f f 0f0f0f0f
1 0 e0000005 00007700 e0000005 2 f 00000000
0 2 e0000004 00000000 e0000004 f f 00007700
0 2 00005000 00000000 00005000 f f 00000000
1 0 a0001003 99000000 00001003 8 0 00000000
0 2 80001000 00000000 00001000 f f 99efaa44

//--- all.f
+incdir+source
source/mem_bus_pkg.sv
source/sram_req_decode.sv
source/axi_chan_slot.sv
source/axi_txn_ctrl.sv
source/mips_axi_bridge.sv
sim/tb_mips_axi_bridge.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_axi_bridge
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_mips_axi_bridge.sv
`default_nettype none

`include "mem_bus_consts.svh"

module tb_mips_axi_bridge;

  localparam int MAX_RECS = 64;
  localparam int TIMEOUT  = 200;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   req;
  mem_bus_pkg::sram_req_t req_info;
  logic                   addr_ok;
  logic                   data_ok;
  logic [`MEM_DATA_W-1:0] rdata;
  logic                   arvalid;
  logic                   arready;
  logic                   awvalid;
  logic                   awready;
  logic                   wvalid;
  logic                   wready;
  logic                   rvalid;
  logic                   rready;
  logic                   bvalid;
  logic                   bready;
  mem_bus_pkg::axi_addr_t ar;
  mem_bus_pkg::axi_addr_t aw;
  mem_bus_pkg::axi_w_t    w;
  mem_bus_pkg::axi_r_t    r;

  // eight words per access in stimulus file column order
  logic [31:0] stim [0:MAX_RECS*8-1];

  // expected fields of the access in flight
  logic        exp_wr;
  logic [1:0]  exp_size;
  logic [31:0] exp_paddr;
  logic [31:0] exp_wdata;
  logic [3:0]  exp_strb;
  logic [3:0]  exp_cache;
  logic [31:0] exp_rdata;

  // slave model state
  logic [31:0]            mem_words [logic [31:0]];
  int                     ar_wait, aw_wait, w_wait, r_wait, b_wait;
  int                     ar_cnt, aw_cnt, w_cnt, r_cnt, b_cnt;
  logic                   r_pending, r_fire, b_pending, b_fire, aw_got, w_got;
  logic                   ar_held, aw_held, w_held;
  logic [31:0]            ar_addr_q, aw_addr_q;
  mem_bus_pkg::axi_addr_t ar_prev, aw_prev;
  mem_bus_pkg::axi_w_t    w_prev, w_q;

  always #4 clk = ~clk;

  mips_axi_bridge dut_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .req_info (req_info),
    .addr_ok  (addr_ok),
    .data_ok  (data_ok),
    .rdata    (rdata),
    .arvalid  (arvalid),
    .ar       (ar),
    .arready  (arready),
    .awvalid  (awvalid),
    .aw       (aw),
    .awready  (awready),
    .wvalid   (wvalid),
    .w        (w),
    .wready   (wready),
    .rvalid   (rvalid),
    .r        (r),
    .rready   (rready),
    .bvalid   (bvalid),
    .bready   (bready)
  );

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("TEST FAILED");
    $fatal(1, "%s", why);
  endtask

  // unwritten words read back as zero
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] word;
    word = '0;
    if (mem_words.exists({addr[31:2], 2'b00})) begin
      word = mem_words[{addr[31:2], 2'b00}];
    end
    return word;
  endfunction

  task automatic check_addr(input string ch, input mem_bus_pkg::axi_addr_t a);
    check({ch, ".id"}, 64'(a.id), 64'(`AXI_DATA_ID));
    check({ch, ".addr"}, 64'(a.addr), 64'(exp_paddr));
    check({ch, ".len"}, 64'(a.len), 64'd0);
    check({ch, ".size"}, 64'(a.size), 64'(exp_size));
    check({ch, ".burst"}, 64'(a.burst), 64'(`AXI_BURST_INCR));
    check({ch, ".cache"}, 64'(a.cache), 64'(exp_cache));
  endtask

  // ready rises after a random delay and the handshake follows on the next rising edge
  task automatic serve_ar();
    if (!arvalid) begin
      arready = 1'b0;
      ar_wait = $urandom % 4;
    end else if (ar_wait != 0) begin
      ar_wait--;
    end else begin
      if (exp_wr) begin
        abort_run("read address issued for a write access");
      end
      arready = 1'b1;
      check_addr("ar", ar);
      ar_addr_q = ar.addr;
      ar_cnt++;
      r_pending = 1'b1;
      r_wait = 1 + $urandom % 4;
    end
  endtask

  task automatic serve_aw();
    if (!awvalid) begin
      awready = 1'b0;
      aw_wait = $urandom % 4;
    end else if (aw_wait != 0) begin
      aw_wait--;
    end else begin
      if (!exp_wr) begin
        abort_run("write address issued for a read access");
      end
      awready = 1'b1;
      check_addr("aw", aw);
      aw_addr_q = aw.addr;
      aw_got = 1'b1;
      aw_cnt++;
    end
  endtask

  task automatic serve_w();
    if (!wvalid) begin
      wready = 1'b0;
      w_wait = $urandom % 4;
    end else if (w_wait != 0) begin
      w_wait--;
    end else begin
      if (!exp_wr) begin
        abort_run("write data issued for a read access");
      end
      wready = 1'b1;
      check("w.data", 64'(w.data), 64'(exp_wdata));
      check("w.strb", 64'(w.strb), 64'(exp_strb));
      check("w.last", 64'(w.last), 64'd1);
      w_q = w;
      w_got = 1'b1;
      w_cnt++;
    end
  endtask

  // merge the strobed lanes and schedule b
  task automatic store_write();
    logic [31:0] word;
    word = read_word(aw_addr_q);
    for (int i = 0; i < 4; i++) begin
      if (w_q.strb[i]) begin
        word[8*i +: 8] = w_q.data[8*i +: 8];
      end
    end
    mem_words[{aw_addr_q[31:2], 2'b00}] = word;
    aw_got = 1'b0;
    w_got = 1'b0;
    b_pending = 1'b1;
    b_wait = 1 + $urandom % 4;
  endtask

  task automatic serve_r();
    if (r_fire) begin
      rvalid = 1'b0;
      r_fire = 1'b0;
    end else if (r_pending) begin
      if (r_wait != 0) begin
        r_wait--;
      end else begin
        rvalid = 1'b1;
        r.data = read_word(ar_addr_q);
        r.resp = 2'b00;
        r.last = 1'b1;
      end
    end
    if (rvalid && rready) begin
      r_fire = 1'b1;
      r_pending = 1'b0;
      r_cnt++;
    end
  endtask

  task automatic serve_b();
    if (b_fire) begin
      bvalid = 1'b0;
      b_fire = 1'b0;
    end else if (b_pending) begin
      if (b_wait != 0) begin
        b_wait--;
      end else begin
        bvalid = 1'b1;
      end
    end
    if (bvalid && bready) begin
      b_fire = 1'b1;
      b_pending = 1'b0;
      b_cnt++;
    end
  endtask

  // slave outputs all change on the falling edge
  initial begin
    void'($urandom(32'ha0d3_8c7f));
    arready = 1'b0;
    awready = 1'b0;
    wready = 1'b0;
    rvalid = 1'b0;
    bvalid = 1'b0;
    r = '0;
    {r_pending, r_fire, b_pending, b_fire, aw_got, w_got} = '0;
    {ar_held, aw_held, w_held} = '0;
    forever begin
      @(negedge clk);
      // a request left waiting must not move
      if (ar_held) begin
        check("arvalid", 64'(arvalid), 64'd1);
        check("ar", 64'(ar), 64'(ar_prev));
      end
      if (aw_held) begin
        check("awvalid", 64'(awvalid), 64'd1);
        check("aw", 64'(aw), 64'(aw_prev));
      end
      if (w_held) begin
        check("wvalid", 64'(wvalid), 64'd1);
        check("w", 64'(w), 64'(w_prev));
      end
      serve_ar();
      serve_aw();
      serve_w();
      if (aw_got && w_got) begin
        store_write();
      end
      serve_r();
      serve_b();
      ar_held = arvalid && !arready;
      aw_held = awvalid && !awready;
      w_held = wvalid && !wready;
      ar_prev = ar;
      aw_prev = aw;
      w_prev = w;
    end
  end

  task automatic run_access(input int rec);
    int base;
    int cnt;
    int rd;
    int ar0, aw0, w0, r0, b0;
    base = rec * 8;
    exp_wr = stim[base][0];
    exp_size = stim[base+1][1:0];
    exp_wdata = stim[base+3];
    exp_paddr = stim[base+4];
    exp_strb = stim[base+5][3:0];
    exp_cache = stim[base+6][3:0];
    exp_rdata = stim[base+7];
    rd = exp_wr ? 0 : 1;
    {ar0, aw0, w0, r0, b0} = {ar_cnt, aw_cnt, w_cnt, r_cnt, b_cnt};
    req_info.wr = exp_wr;
    req_info.size = exp_size;
    req_info.addr = stim[base+2];
    req_info.wdata = exp_wdata;
    req = 1'b1;
    cnt = 0;
    while (!addr_ok) begin
      check("data_ok", 64'(data_ok), 64'd0);
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) begin
        abort_run("timed out waiting for addr_ok");
      end
    end
    // the request is taken on this rising edge and must be held inside
    @(negedge clk);
    req = 1'b0;
    req_info.addr = ~req_info.addr;
    cnt = 0;
    while (!data_ok) begin
      check("addr_ok", 64'(addr_ok), 64'd0);
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) begin
        abort_run("timed out waiting for data_ok");
      end
    end
    check("addr_ok", 64'(addr_ok), 64'd0);
    if (!exp_wr) begin
      check("rdata", 64'(rdata), 64'(exp_rdata));
    end
    @(negedge clk);
    check("data_ok", 64'(data_ok), 64'd0);
    check("addr_ok", 64'(addr_ok), 64'd1);
    check("ar handshakes", 64'(ar_cnt - ar0), 64'(rd));
    check("r handshakes", 64'(r_cnt - r0), 64'(rd));
    check("aw handshakes", 64'(aw_cnt - aw0), 64'(1 - rd));
    check("w handshakes", 64'(w_cnt - w0), 64'(1 - rd));
    check("b handshakes", 64'(b_cnt - b0), 64'(1 - rd));
    repeat (rec % 3) begin
      @(negedge clk);
      check("data_ok", 64'(data_ok), 64'd0);
    end
  endtask

  initial begin
    int rec;
    for (int i = 0; i < MAX_RECS * 8; i++) begin
      stim[i] = 32'hffff_ffff;
    end
    $readmemh("sim/bridge_stim.txt", stim);
    rst = 1'b1;
    req = 1'b0;
    req_info = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check("arvalid", 64'(arvalid), 64'd0);
    check("awvalid", 64'(awvalid), 64'd0);
    check("wvalid", 64'(wvalid), 64'd0);
    check("rready", 64'(rready), 64'd0);
    check("bready", 64'(bready), 64'd0);
    check("data_ok", 64'(data_ok), 64'd0);
    check("addr_ok", 64'(addr_ok), 64'd1);
    rec = 0;
    // an all ones wr column ends the list
    while (rec < MAX_RECS && stim[rec*8] != 32'hffff_ffff) begin
      run_access(rec);
      rec++;
    end
    if (rec == 0) begin
      abort_run("the stimulus file holds no accesses");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- source/mips_axi_bridge.sv
`default_nettype none

`include "mem_bus_consts.svh"

module mips_axi_bridge (
  input  wire                         clk,
  input  wire                         rst,
  // sram-like data port
  input  wire                         req,
  input  wire mem_bus_pkg::sram_req_t req_info,
  output logic                        addr_ok,
  output logic                        data_ok,
  output logic [`MEM_DATA_W-1:0]      rdata,
  // ar
  output logic                        arvalid,
  output mem_bus_pkg::axi_addr_t      ar,
  input  wire                         arready,
  // aw
  output logic                        awvalid,
  output mem_bus_pkg::axi_addr_t      aw,
  input  wire                         awready,
  // w
  output logic                        wvalid,
  output mem_bus_pkg::axi_w_t         w,
  input  wire                         wready,
  // r
  input  wire                         rvalid,
  input  wire mem_bus_pkg::axi_r_t    r,
  output logic                        rready,
  // b
  input  wire                         bvalid,
  output logic                        bready
);

  mem_bus_pkg::bus_txn_t  txn;
  mem_bus_pkg::axi_addr_t ar_payload;
  mem_bus_pkg::axi_addr_t aw_payload;
  mem_bus_pkg::axi_w_t    w_payload;
  logic                   ar_load;
  logic                   aw_load;
  logic                   w_load;
  logic                   ar_busy;
  logic                   aw_busy;
  logic                   w_busy;

  sram_req_decode decode_i (
    .req_info (req_info),
    .txn      (txn)
  );

  axi_txn_ctrl ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .txn        (txn),
    .addr_ok    (addr_ok),
    .data_ok    (data_ok),
    .rdata      (rdata),
    .ar_load    (ar_load),
    .aw_load    (aw_load),
    .w_load     (w_load),
    .ar_payload (ar_payload),
    .aw_payload (aw_payload),
    .w_payload  (w_payload),
    .ar_busy    (ar_busy),
    .aw_busy    (aw_busy),
    .w_busy     (w_busy),
    .rvalid     (rvalid),
    .r          (r),
    .rready     (rready),
    .bvalid     (bvalid),
    .bready     (bready)
  );

  // one holding slot per request channel
  axi_chan_slot #(.payload_t(mem_bus_pkg::axi_addr_t)) ar_slot (
    .clk        (clk),
    .rst        (rst),
    .load       (ar_load),
    .payload_in (ar_payload),
    .ready      (arready),
    .valid      (arvalid),
    .payload    (ar),
    .busy       (ar_busy)
  );

  axi_chan_slot #(.payload_t(mem_bus_pkg::axi_addr_t)) aw_slot (
    .clk        (clk),
    .rst        (rst),
    .load       (aw_load),
    .payload_in (aw_payload),
    .ready      (awready),
    .valid      (awvalid),
    .payload    (aw),
    .busy       (aw_busy)
  );

  axi_chan_slot #(.payload_t(mem_bus_pkg::axi_w_t)) w_slot (
    .clk        (clk),
    .rst        (rst),
    .load       (w_load),
    .payload_in (w_payload),
    .ready      (wready),
    .valid      (wvalid),
    .payload    (w),
    .busy       (w_busy)
  );

endmodule

`default_nettype wire

//--- source/axi_txn_ctrl.sv
`default_nettype none

`include "mem_bus_consts.svh"

module axi_txn_ctrl (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         req,
  input  wire mem_bus_pkg::bus_txn_t  txn,
  output logic                        addr_ok,
  output logic                        data_ok,
  output logic [`MEM_DATA_W-1:0]      rdata,
  output logic                        ar_load,
  output logic                        aw_load,
  output logic                        w_load,
  output mem_bus_pkg::axi_addr_t      ar_payload,
  output mem_bus_pkg::axi_addr_t      aw_payload,
  output mem_bus_pkg::axi_w_t         w_payload,
  input  wire                         ar_busy,
  input  wire                         aw_busy,
  input  wire                         w_busy,
  input  wire                         rvalid,
  input  wire mem_bus_pkg::axi_r_t    r,
  output logic                        rready,
  input  wire                         bvalid,
  output logic                        bready
);

  typedef enum logic [2:0] {
    st_idle,
    st_issue,
    st_wait_addr,
    st_wait_resp,
    st_done
  } state_t;

  state_t                 state;
  state_t                 state_next;
  mem_bus_pkg::bus_txn_t  txn_q;
  mem_bus_pkg::axi_addr_t addr_payload;
  logic [`MEM_DATA_W-1:0] rdata_q;
  logic                   accept;

  assign addr_ok = (state == st_idle);
  assign accept  = req && addr_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // hold the decoded request for the whole transaction
  always_ff @(posedge clk) begin
    if (accept) begin
      txn_q <= txn;
    end
  end

  always_ff @(posedge clk) begin
    if (rready && rvalid) begin
      rdata_q <= r.data;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (req) begin
          state_next = st_issue;
        end
      end
      st_issue: begin
        state_next = st_wait_addr;
      end
      st_wait_addr: begin
        // aw and w may finish in any order
        if (txn_q.wr ? (!aw_busy && !w_busy) : !ar_busy) begin
          state_next = st_wait_resp;
        end
      end
      st_wait_resp: begin
        if (txn_q.wr ? bvalid : rvalid) begin
          state_next = st_done;
        end
      end
      st_done: begin
        state_next = st_idle;
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  // slot loads, one cycle after acceptance
  assign ar_load = (state == st_issue) && !txn_q.wr;
  assign aw_load = (state == st_issue) && txn_q.wr;
  assign w_load  = (state == st_issue) && txn_q.wr;

  // single beat incr, same fields for ar and aw
  always_comb begin
    addr_payload.id    = `AXI_DATA_ID;
    addr_payload.addr  = txn_q.paddr;
    addr_payload.len   = 8'd0;
    addr_payload.size  = {1'b0, txn_q.size};
    addr_payload.burst = `AXI_BURST_INCR;
    addr_payload.cache = txn_q.cache;
  end

  assign ar_payload = addr_payload;
  assign aw_payload = addr_payload;

  always_comb begin
    w_payload.data = txn_q.wdata;
    w_payload.strb = txn_q.strb;
    w_payload.last = 1'b1;
  end

  // responses are always taken once waiting
  assign rready  = (state == st_wait_resp) && !txn_q.wr;
  assign bready  = (state == st_wait_resp) && txn_q.wr;

  assign data_ok = (state == st_done);
  assign rdata   = rdata_q;

endmodule

`default_nettype wire

//--- source/axi_chan_slot.sv
`default_nettype none

module axi_chan_slot #(
  parameter type payload_t = logic
) (
  input  wire           clk,
  input  wire           rst,
  input  wire           load,
  input  wire payload_t payload_in,
  input  wire           ready,
  output logic          valid,
  output payload_t      payload,
  output logic          busy
);

  // valid rises after load, falls after the handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (ready) begin
      valid <= 1'b0;
    end
  end

  // payload only changes on load, so it is stable while valid
  always_ff @(posedge clk) begin
    if (load) begin
      payload <= payload_in;
    end
  end

  assign busy = valid;

endmodule

`default_nettype wire

//--- source/sram_req_decode.sv
`default_nettype none

`include "mem_bus_consts.svh"

module sram_req_decode (
  input  wire mem_bus_pkg::sram_req_t req_info,
  output mem_bus_pkg::bus_txn_t       txn
);

  logic                   in_kseg0;
  logic                   in_kseg1;
  logic [`MEM_ADDR_W-1:0] paddr;
  logic [`MEM_STRB_W-1:0] strb;

  // segment decode on the virtual address
  assign in_kseg0 = (req_info.addr >= `KSEG0_BASE) && (req_info.addr < `KSEG1_BASE);
  assign in_kseg1 = (req_info.addr >= `KSEG1_BASE) && (req_info.addr < `KSEG2_BASE);

  // kseg0/kseg1 are unmapped windows onto low memory
  always_comb begin
    if (in_kseg0) begin
      paddr = req_info.addr - `KSEG0_BASE;
    end else if (in_kseg1) begin
      paddr = req_info.addr - `KSEG1_BASE;
    end else begin
      // kuseg and kseg2/3 go out as they are
      paddr = req_info.addr;
    end
  end

  // byte lanes from size and offset
  always_comb begin
    case (req_info.size)
      2'd0: begin
        strb = 4'b0001 << req_info.addr[1:0];
      end
      2'd1: begin
        if (req_info.addr[1]) begin
          strb = 4'b1100;
        end else begin
          strb = 4'b0011;
        end
      end
      default: begin
        strb = 4'b1111;
      end
    endcase
  end

  always_comb begin
    txn.wr    = req_info.wr;
    txn.size  = req_info.size;
    txn.paddr = paddr;
    txn.wdata = req_info.wdata;
    txn.strb  = strb;
    // only kseg1 bypasses the caches
    if (in_kseg1) begin
      txn.cache = `AXI_CACHE_UNCACHED;
    end else begin
      txn.cache = `AXI_CACHE_CACHED;
    end
  end

endmodule

`default_nettype wire

//--- source/mem_bus_pkg.sv
`default_nettype none

`include "mem_bus_consts.svh"

package mem_bus_pkg;

  // sram-like request, wdata already on its byte lanes
  typedef struct packed {
    logic                   wr;
    logic [1:0]             size;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] wdata;
  } sram_req_t;

  // request after translation and strobe decode
  typedef struct packed {
    logic                   wr;
    logic [1:0]             size;
    logic [`MEM_ADDR_W-1:0] paddr;
    logic [`MEM_DATA_W-1:0] wdata;
    logic [`MEM_STRB_W-1:0] strb;
    logic [3:0]             cache;
  } bus_txn_t;

  // ar and aw payload
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [1:0]             burst;
    logic [3:0]             cache;
  } axi_addr_t;

  typedef struct packed {
    logic [`MEM_DATA_W-1:0] data;
    logic [`MEM_STRB_W-1:0] strb;
    logic                   last;
  } axi_w_t;

  typedef struct packed {
    logic [`MEM_DATA_W-1:0] data;
    logic [1:0]             resp;
    logic                   last;
  } axi_r_t;

endpackage

`default_nettype wire

//--- source/mem_bus_consts.svh
`ifndef MEM_BUS_CONSTS_SVH
`define MEM_BUS_CONSTS_SVH

// data side bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32
`define MEM_STRB_W 4

// axi id width and the id used by the data port
`define AXI_ID_W    4
`define AXI_DATA_ID 4'd1

// fixed segment map, kuseg below kseg0
`define KSEG0_BASE 32'h8000_0000
`define KSEG1_BASE 32'hA000_0000
`define KSEG2_BASE 32'hC000_0000

// axi burst type
`define AXI_BURST_INCR 2'b01

// arcache/awcache codes
`define AXI_CACHE_UNCACHED 4'h0
`define AXI_CACHE_CACHED   4'hF

`endif
